// ==== project.f ====
rtl/spi_pkg.sv
rtl/spi_sck_gen.sv
rtl/spi_shifter.sv
rtl/spi_transfer_ctrl.sv
rtl/spi_stream_master.sv
verif/spi_slave_model.sv
verif/tb_spi_stream_master.sv

// ==== Bender.yml ====
package:
  name: spi_stream_master

sources:
  - files:
      - rtl/spi_pkg.sv
      - rtl/spi_sck_gen.sv
      - rtl/spi_shifter.sv
      - rtl/spi_transfer_ctrl.sv
      - rtl/spi_stream_master.sv
  - target: test
    files:
      - verif/spi_slave_model.sv
      - verif/tb_spi_stream_master.sv

// ==== verif/tb_spi_stream_master.sv ====
`timescale 1ns/1ps

module tb_spi_stream_master;

    localparam int W           = spi_pkg::WORD_WIDTH;
    localparam int CLK_PERIOD  = 40;
    localparam int DRIVE_DELAY = 2;
    // setup half-bit, 2W-1 edge spacings, hold half-bit
    localparam int XFER_CYCLES = spi_pkg::HALF_BIT_CYCLES * (2 * W + 1);
    localparam int WAIT_LIMIT  = 2 * XFER_CYCLES;
    localparam int STALL_CYCLES = 20;
    // 1 single, 6 back-to-back, 2 with miso_en low, 2 under back-pressure
    localparam int TOTAL_WORDS = 11;
    localparam int WATCHDOG_NS = (TOTAL_WORDS * XFER_CYCLES + 200) * CLK_PERIOD * 2;

    logic               mosi_stream;
    logic               reset;
    logic               miso_en;
    spi_pkg::spi_word_t mosi_tdata;
    logic               mosi_tvalid;
    logic               mosi_tready;
    spi_pkg::spi_word_t miso_tdata;
    logic               miso_tvalid;
    logic               miso_tready;
    logic               sck;
    logic               cs_n;
    logic               mosi;
    logic               miso;

    spi_pkg::spi_word_t slave_reply;
    spi_pkg::spi_word_t slave_rx;
    int                 slave_count;
    int                 slave_bits;

    int          errors       = 0;
    int          checks       = 0;
    int          tests_run    = 0;
    int          tests_failed = 0;
    int          words_sent   = 0;
    logic [31:0] lfsr_state   = 32'he71deaaf;

    spi_stream_master dut_i (
        .mosi_stream (mosi_stream),
        .reset       (reset),
        .miso_en     (miso_en),
        .mosi_tdata  (mosi_tdata),
        .mosi_tvalid (mosi_tvalid),
        .mosi_tready (mosi_tready),
        .miso_tdata  (miso_tdata),
        .miso_tvalid (miso_tvalid),
        .miso_tready (miso_tready),
        .sck         (sck),
        .cs_n        (cs_n),
        .mosi        (mosi),
        .miso        (miso)
    );

    spi_slave_model slave_i (
        .sck        (sck),
        .cs_n       (cs_n),
        .mosi       (mosi),
        .miso       (miso),
        .reply_word (slave_reply),
        .rx_word    (slave_rx),
        .word_count (slave_count),
        .bit_count  (slave_bits)
    );

    initial begin
        mosi_stream = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) mosi_stream = ~mosi_stream;
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("ERROR: watchdog expired after %0d ns, the run did not finish", WATCHDOG_NS);
        $display("FAIL: see errors above");
        $finish;
    end

    // galois form, taps for x^32 + x^22 + x^2 + x + 1
    function automatic logic lfsr_bit();
        logic out;
        out = lfsr_state[0];
        lfsr_state = {1'b0, lfsr_state[31:1]} ^ (out ? 32'h80200003 : 32'h0);
        return out;
    endfunction

    function automatic spi_pkg::spi_word_t random_word();
        spi_pkg::spi_word_t word;
        word = '0;
        for (int i = 0; i < W; i++) begin
            word = {word[W-2:0], lfsr_bit()};
        end
        return word;
    endfunction

    task automatic next_cycle();
        @(posedge mosi_stream);
        #DRIVE_DELAY;
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        checks++;
        assert (got === expected) else begin
            errors++;
            $display("CHECK FAILED: %s is 0x%h, expected 0x%h at %0t", name, got, expected,
                     $time);
        end
    endtask

    task automatic report_failure(input string msg);
        errors++;
        $display("ERROR: %s at %0t", msg, $time);
    endtask

    task automatic end_test(input string name, input int start_errors);
        tests_run++;
        if (errors == start_errors) begin
            $display("test %s: passed", name);
        end else begin
            tests_failed++;
            $display("test %s: failed with %0d errors", name, errors - start_errors);
        end
    endtask

    // one word through the MOSI stream and over the bus, checked at the slave
    task automatic send_word(input spi_pkg::spi_word_t word);
        int waited;
        int xfer_len;
        mosi_tdata  = word;
        mosi_tvalid = 1'b1;
        waited = 0;
        while (!mosi_tready && waited < WAIT_LIMIT) begin
            next_cycle();
            waited++;
        end
        assert (mosi_tready) else report_failure("mosi_tready never rose, word not accepted");
        if (mosi_tready) begin
            // handshake happens on this edge
            next_cycle();
            mosi_tvalid = 1'b0;
            check_value("cs_n", cs_n, 1'b0);
            check_value("mosi", mosi, word[W-1]);
            xfer_len = 0;
            while (!cs_n && xfer_len < WAIT_LIMIT) begin
                next_cycle();
                xfer_len++;
            end
            assert (cs_n) else report_failure("cs_n stayed low, transfer never ended");
            words_sent++;
            check_value("transfer cycles", xfer_len, XFER_CYCLES);
            check_value("slave word_count", slave_count, words_sent);
            check_value("slave bit_count", slave_bits, W);
            check_value("slave rx_word", slave_rx, word);
        end else begin
            mosi_tvalid = 1'b0;
        end
    endtask

    // waits for the captured word and takes it off the MISO stream
    task automatic expect_word(input spi_pkg::spi_word_t reply);
        int waited;
        waited = 0;
        while (!miso_tvalid && waited < WAIT_LIMIT) begin
            next_cycle();
            waited++;
        end
        assert (miso_tvalid) else report_failure("miso_tvalid never rose, reply not delivered");
        if (miso_tvalid) begin
            check_value("miso_tdata", miso_tdata, reply);
            check_value("cs_n", cs_n, 1'b1);
            miso_tready = 1'b1;
            next_cycle();
            check_value("miso_tvalid", miso_tvalid, 1'b0);
        end
    endtask

    task automatic test_reset_state();
        int start_errors;
        int waited;
        start_errors = errors;
        reset = 1'b1;
        next_cycle();
        check_value("mosi_tready", mosi_tready, 1'b0);
        check_value("miso_tvalid", miso_tvalid, 1'b0);
        check_value("cs_n", cs_n, 1'b1);
        next_cycle();
        reset = 1'b0;
        waited = 0;
        while (!mosi_tready && waited < 4) begin
            next_cycle();
            waited++;
        end
        assert (mosi_tready) else report_failure("mosi_tready did not rise after reset");
        check_value("cs_n", cs_n, 1'b1);
        check_value("sck", sck, 1'b0);
        check_value("mosi", mosi, 1'b0);
        check_value("miso_tvalid", miso_tvalid, 1'b0);
        end_test("reset state", start_errors);
    endtask

    task automatic test_single_transfer();
        int start_errors;
        start_errors = errors;
        miso_en     = 1'b1;
        slave_reply = 8'hc3;
        send_word(8'h96);
        expect_word(8'hc3);
        end_test("single transfer", start_errors);
    endtask

    task automatic test_back_to_back();
        int                 start_errors;
        spi_pkg::spi_word_t tx;
        spi_pkg::spi_word_t rx;
        start_errors = errors;
        miso_tready  = 1'b1;
        for (int i = 0; i < 6; i++) begin
            tx = random_word();
            rx = random_word();
            slave_reply = rx;
            send_word(tx);
            expect_word(rx);
        end
        end_test("back-to-back words", start_errors);
    endtask

    task automatic test_miso_en_low();
        int start_errors;
        start_errors = errors;
        miso_en = 1'b0;
        repeat (2) begin
            slave_reply = random_word();
            send_word(random_word());
            repeat (8) begin
                check_value("miso_tvalid", miso_tvalid, 1'b0);
                next_cycle();
            end
        end
        miso_en = 1'b1;
        end_test("miso_en low", start_errors);
    endtask

    task automatic test_back_pressure();
        int                 start_errors;
        spi_pkg::spi_word_t reply_a;
        spi_pkg::spi_word_t word_b;
        spi_pkg::spi_word_t reply_b;
        start_errors = errors;
        miso_tready  = 1'b0;
        reply_a      = random_word();
        slave_reply  = reply_a;
        send_word(random_word());
        word_b      = random_word();
        reply_b     = random_word();
        slave_reply = reply_b;
        mosi_tdata  = word_b;
        mosi_tvalid = 1'b1;
        // second word offered while the first reply is stuck
        repeat (STALL_CYCLES) begin
            check_value("mosi_tready", mosi_tready, 1'b0);
            check_value("cs_n", cs_n, 1'b1);
            check_value("miso_tvalid", miso_tvalid, 1'b1);
            check_value("miso_tdata", miso_tdata, reply_a);
            next_cycle();
        end
        expect_word(reply_a);
        send_word(word_b);
        expect_word(reply_b);
        end_test("miso back-pressure", start_errors);
    endtask

    initial begin
        reset       = 1'b1;
        miso_en     = 1'b1;
        mosi_tdata  = '0;
        mosi_tvalid = 1'b0;
        miso_tready = 1'b1;
        slave_reply = '0;
        test_reset_state();
        test_single_transfer();
        test_back_to_back();
        test_miso_en_low();
        test_back_pressure();
        $display("tests run %0d, tests failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

// ==== verif/spi_slave_model.sv ====
`timescale 1ns/1ps

// behavioral mode 0 SPI slave
module spi_slave_model (
    input  logic               sck,
    input  logic               cs_n,
    input  logic               mosi,
    output logic               miso,
    input  spi_pkg::spi_word_t reply_word,
    output spi_pkg::spi_word_t rx_word,
    output int                 word_count,
    output int                 bit_count
);

    localparam int W = spi_pkg::WORD_WIDTH;

    spi_pkg::spi_word_t tx_shift;
    spi_pkg::spi_word_t rx_shift;
    int                 bits_seen;
    logic               selected = 1'b0;

    initial begin
        rx_word    = '0;
        word_count = 0;
        bit_count  = 0;
    end

    // reply MSB goes out as soon as the slave is selected
    always @(negedge cs_n) begin
        selected  = 1'b1;
        tx_shift  = reply_word;
        rx_shift  = '0;
        bits_seen = 0;
    end

    // mode 0 samples on the rising edge
    always @(posedge sck) begin
        if (selected) begin
            rx_shift  = {rx_shift[W-2:0], mosi};
            bits_seen = bits_seen + 1;
        end
    end

    // and moves to the next reply bit on the falling edge
    always @(negedge sck) begin
        if (selected) begin
            tx_shift = {tx_shift[W-2:0], 1'b0};
        end
    end

    // word is complete once chip select is released
    always @(posedge cs_n) begin
        if (selected) begin
            selected   = 1'b0;
            rx_word    = rx_shift;
            bit_count  = bits_seen;
            word_count = word_count + 1;
        end
    end

    assign miso = selected ? tx_shift[W-1] : 1'b0;

endmodule

// ==== rtl/spi_stream_master.sv ====
`timescale 1ns/1ps

module spi_stream_master (
    input  logic                mosi_stream,
    input  logic                reset,
    input  logic                miso_en,
    input  spi_pkg::spi_word_t  mosi_tdata,
    input  logic                mosi_tvalid,
    output logic                mosi_tready,
    output spi_pkg::spi_word_t  miso_tdata,
    output logic                miso_tvalid,
    input  logic                miso_tready,
    output logic                sck,
    output logic                cs_n,
    output logic                mosi,
    input  logic                miso
);

    logic load;
    logic run;
    logic sample_stb;
    logic shift_stb;
    logic edge_done;

    spi_transfer_ctrl ctrl_i (
        .mosi_stream (mosi_stream),
        .reset       (reset),
        .miso_en     (miso_en),
        .mosi_tvalid (mosi_tvalid),
        .miso_tready (miso_tready),
        .edge_done   (edge_done),
        .mosi_tready (mosi_tready),
        .miso_tvalid (miso_tvalid),
        .load        (load),
        .run         (run),
        .cs_n        (cs_n)
    );

    spi_sck_gen sck_gen_i (
        .mosi_stream (mosi_stream),
        .reset       (reset),
        .run         (run),
        .sck         (sck),
        .sample_stb  (sample_stb),
        .shift_stb   (shift_stb),
        .edge_done   (edge_done)
    );

    // stream data goes straight into the shifter, captured word straight out
    spi_shifter shifter_i (
        .mosi_stream (mosi_stream),
        .reset       (reset),
        .load        (load),
        .tx_word     (mosi_tdata),
        .sample_stb  (sample_stb),
        .shift_stb   (shift_stb),
        .miso        (miso),
        .mosi        (mosi),
        .rx_word     (miso_tdata)
    );

endmodule

// ==== rtl/spi_transfer_ctrl.sv ====
`timescale 1ns/1ps

module spi_transfer_ctrl (
    input  logic mosi_stream,
    input  logic reset,
    input  logic miso_en,
    input  logic mosi_tvalid,
    input  logic miso_tready,
    input  logic edge_done,
    output logic mosi_tready,
    output logic miso_tvalid,
    output logic load,
    output logic run,
    output logic cs_n
);

    spi_pkg::xfer_state_t state;
    spi_pkg::half_count_t half_cnt;
    logic                 deliver_en;
    logic                 half_done;

    // word accepted from the MOSI stream
    assign load = mosi_tvalid && mosi_tready;

    assign half_done = (half_cnt == spi_pkg::half_count_t'(spi_pkg::HALF_BIT_CYCLES - 1));

    // sck generator runs from cs_n low until cs_n high
    assign run = (state == spi_pkg::SETUP) ||
                 (state == spi_pkg::SHIFT) ||
                 (state == spi_pkg::HOLD);

    // captured word waits here until taken
    assign miso_tvalid = (state == spi_pkg::DELIVER);

    always_ff @(posedge mosi_stream) begin
        if (reset) begin
            state      <= spi_pkg::IDLE;
            half_cnt   <= '0;
            deliver_en <= 1'b0;
            cs_n       <= 1'b1;
        end else begin
            case (state)
                spi_pkg::IDLE: begin
                    if (load) begin
                        state      <= spi_pkg::SETUP;
                        cs_n       <= 1'b0;
                        // decided per word, at accept time
                        deliver_en <= miso_en;
                    end
                end
                // one half-bit of cs_n low before the first sck edge
                spi_pkg::SETUP: begin
                    if (half_done) begin
                        state    <= spi_pkg::SHIFT;
                        half_cnt <= '0;
                    end else begin
                        half_cnt <= half_cnt + 1'b1;
                    end
                end
                spi_pkg::SHIFT: begin
                    if (edge_done) begin
                        state <= spi_pkg::HOLD;
                    end
                end
                // one half-bit after the last edge before cs_n rises
                spi_pkg::HOLD: begin
                    if (half_done) begin
                        half_cnt <= '0;
                        cs_n     <= 1'b1;
                        state    <= deliver_en ? spi_pkg::DELIVER : spi_pkg::IDLE;
                    end else begin
                        half_cnt <= half_cnt + 1'b1;
                    end
                end
                spi_pkg::DELIVER: begin
                    if (miso_tready) begin
                        state <= spi_pkg::IDLE;
                    end
                end
                default: begin
                    state <= spi_pkg::IDLE;
                end
            endcase
        end
    end

    // ready only after a full cycle in IDLE, dropped on accept
    always_ff @(posedge mosi_stream) begin
        if (reset) begin
            mosi_tready <= 1'b0;
        end else begin
            mosi_tready <= (state == spi_pkg::IDLE) && !load;
        end
    end

    // no new word can be taken while a transfer holds the bus
    no_ready_in_transfer: assert property (
        @(posedge mosi_stream) disable iff (reset)
        mosi_tready |-> cs_n
    );

endmodule

// ==== rtl/spi_shifter.sv ====
`timescale 1ns/1ps

module spi_shifter (
    input  logic                mosi_stream,
    input  logic                reset,
    input  logic                load,
    input  spi_pkg::spi_word_t  tx_word,
    input  logic                sample_stb,
    input  logic                shift_stb,
    input  logic                miso,
    output logic                mosi,
    output spi_pkg::spi_word_t  rx_word
);

    spi_pkg::spi_word_t tx_reg;
    spi_pkg::spi_word_t rx_reg;

    // transmit side, MSB first
    always_ff @(posedge mosi_stream) begin
        if (reset) begin
            tx_reg <= '0;
        end else if (load) begin
            tx_reg <= tx_word;
        end else if (shift_stb) begin
            tx_reg <= {tx_reg[spi_pkg::WORD_WIDTH-2:0], 1'b0};
        end
    end

    // the top bit is always the one on the wire
    assign mosi = tx_reg[spi_pkg::WORD_WIDTH-1];

    // receive side, first bit in ends up as the MSB
    always_ff @(posedge mosi_stream) begin
        if (sample_stb) begin
            rx_reg <= {rx_reg[spi_pkg::WORD_WIDTH-2:0], miso};
        end
    end

    // no more sample strobes until the next transfer,
    // so the word holds through delivery
    assign rx_word = rx_reg;

endmodule

// ==== rtl/spi_sck_gen.sv ====
`timescale 1ns/1ps

module spi_sck_gen (
    input  logic mosi_stream,
    input  logic reset,
    input  logic run,
    output logic sck,
    output logic sample_stb,
    output logic shift_stb,
    output logic edge_done
);

    spi_pkg::half_count_t half_cnt;
    spi_pkg::bit_count_t  edge_cnt;
    logic                 active;
    logic                 toggle;
    logic                 leading;

    // stop toggling once all edges of the word are out
    assign active = run && (edge_cnt != spi_pkg::bit_count_t'(spi_pkg::EDGE_COUNT));

    // one cycle before sck changes
    assign toggle = active &&
                    (half_cnt == spi_pkg::half_count_t'(spi_pkg::HALF_BIT_CYCLES - 1));

    // leaving the idle level means a leading edge
    assign leading = (sck == spi_pkg::CPOL);

    // mode 0 samples on leading edges and shifts on trailing ones,
    // CPHA swaps the two
    assign sample_stb = toggle && (leading == (spi_pkg::CPHA == 1'b0));
    assign shift_stb  = toggle && (leading != (spi_pkg::CPHA == 1'b0));

    // comes with the strobe of the last edge
    assign edge_done = toggle &&
                       (edge_cnt == spi_pkg::bit_count_t'(spi_pkg::EDGE_COUNT - 1));

    always_ff @(posedge mosi_stream) begin
        if (reset || !run) begin
            half_cnt <= '0;
            edge_cnt <= '0;
            sck      <= spi_pkg::CPOL;
        end else if (toggle) begin
            half_cnt <= '0;
            edge_cnt <= edge_cnt + 1'b1;
            sck      <= ~sck;
        end else if (active) begin
            half_cnt <= half_cnt + 1'b1;
        end
    end

    // the serial clock must rest at its idle level between transfers
    sck_idle_level: assert property (
        @(posedge mosi_stream) disable iff (reset)
        !run |-> (sck == spi_pkg::CPOL)
    );

endmodule

// ==== rtl/spi_pkg.sv ====
package spi_pkg;

    // bits per SPI transfer
    localparam int WORD_WIDTH = 8;

    // system clocks per serial clock half period
    localparam int HALF_BIT_CYCLES = 4;

    // idle level of sck
    localparam logic CPOL = 1'b0;

    // 0 samples on the leading edge, 1 on the trailing edge
    localparam logic CPHA = 1'b0;

    // total sck edges in one transfer
    localparam int EDGE_COUNT = 2 * WORD_WIDTH;

    // stream payload and shift registers
    typedef logic [WORD_WIDTH-1:0] spi_word_t;

    // counts up to EDGE_COUNT edges
    typedef logic [$clog2(EDGE_COUNT + 1)-1:0] bit_count_t;

    // counts system clocks within one half-bit
    typedef logic [$clog2(HALF_BIT_CYCLES + 1)-1:0] half_count_t;

    // transfer controller states
    typedef enum logic [2:0] {
        IDLE,
        SETUP,
        SHIFT,
        HOLD,
        DELIVER
    } xfer_state_t;

endpackage
